//--- files.f
+incdir+.
rvPkg.sv
idExIf.sv
instrDecoder.sv
regFile.sv
decodeExecuteReg.sv
executeStage.sv
rvCoreSlice.sv
rvCoreSlice_sva.sv
rvCoreSlice_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rvCoreSlice_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- rvCoreSlice_tb.sv
`include "rvCore_cfg.svh"

module rvCoreSlice_tb;

    localparam int NUM_INSTR  = 300;
    localparam int MAX_CYCLES = NUM_INSTR * 3 + 50;

    logic            clk;
    logic            rst;
    logic            instrValid;
    rvPkg::instr_u   instr;
    rvPkg::word_t    pc;
    logic            wbValid;
    rvPkg::regAddr_t wbRd;
    rvPkg::word_t    wbData;
    logic            redirect;
    rvPkg::word_t    redirectPc;

    logic [31:0]     lfsr;
    int              cycles;
    rvPkg::word_t    regs [`RV_NREGS];
    rvPkg::word_t    modelPc;

    // expected results of the instruction now in execute, and of the one in writeback.
    logic            exWbValid;
    rvPkg::regAddr_t exWbRd;
    rvPkg::word_t    exWbData;
    logic            exRedirect;
    rvPkg::word_t    exRedirectPc;
    logic            wbExpValid;
    rvPkg::regAddr_t wbExpRd;
    rvPkg::word_t    wbExpData;

    rvCoreSlice u_rvCoreSlice (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .wbValid    (wbValid),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

    bind rvCoreSlice rvCoreSlice_sva u_sva (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .exCtrl   (exIf.ctrl),
        .wbValid  (wbValid),
        .wbRd     (wbRd),
        .redirect (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
        return v;
    endfunction

    function automatic rvPkg::word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // integer ops as the base ISA defines them, alt selects sub and sra.
    function automatic rvPkg::word_t aluModel(input logic [2:0] f3, input logic alt,
                                              input rvPkg::word_t a, input rvPkg::word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? rvPkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input rvPkg::word_t a,
                                         input rvPkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic stopRun(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWb(input logic expValid, input rvPkg::regAddr_t expRd,
                           input rvPkg::word_t expData);
        if (wbValid !== expValid) begin
            stopRun($sformatf("[FAIL] time %0t: wbValid is %b, expected %b",
                              $time, wbValid, expValid));
        end else if (expValid && (wbRd !== expRd || wbData !== expData)) begin
            stopRun($sformatf("[FAIL] time %0t: writeback x%0d = %h, expected x%0d = %h",
                              $time, wbRd, wbData, expRd, expData));
        end
    endtask

    task automatic checkRedirect(input logic expValid, input rvPkg::word_t expPc);
        if (redirect !== expValid) begin
            stopRun($sformatf("[FAIL] time %0t: redirect is %b, expected %b",
                              $time, redirect, expValid));
        end else if (expValid && redirectPc !== expPc) begin
            stopRun($sformatf("[FAIL] time %0t: redirectPc = %h, expected %h",
                              $time, redirectPc, expPc));
        end
    endtask

    task automatic clearExpect();
        exWbValid    = 1'b0;
        exWbRd       = '0;
        exWbData     = '0;
        exRedirect   = 1'b0;
        exRedirectPc = '0;
    endtask

    // outputs are checked half a cycle after the edge that produced them.
    task automatic advance();
        @(negedge clk);
        checkWb(wbExpValid, wbExpRd, wbExpData);
        checkRedirect(exRedirect, exRedirectPc);
        wbExpValid = exWbValid;
        wbExpRd    = exWbRd;
        wbExpData  = exWbData;
    endtask

    // an idle slot or a wrong-path word, neither of which may retire.
    task automatic presentFiller(input logic valid, input rvPkg::word_t fillPc);
        instrValid = valid;
        instr      = randBits(32);
        pc         = fillPc;
        clearExpect();
    endtask

    task automatic presentInstr();
        logic [3:0]      kind;
        logic [2:0]      f3;
        logic            alt;
        logic            jumps;
        rvPkg::regAddr_t rs1;
        rvPkg::regAddr_t rs2;
        rvPkg::regAddr_t rd;
        logic [11:0]     imm12;
        logic [12:0]     immB;
        logic [20:0]     immJ;
        logic [19:0]     immU;
        rvPkg::word_t    a;
        rvPkg::word_t    b;
        rvPkg::word_t    nextPc;
        rvPkg::word_t    value;
        logic [31:0]     word;
        logic            writes;

        kind   = 4'(randBits(4));
        f3     = 3'(randBits(3));
        alt    = 1'(randBits(1));
        rs1    = rvPkg::regAddr_t'(randBits(2));
        rs2    = rvPkg::regAddr_t'(randBits(2));
        rd     = rvPkg::regAddr_t'(randBits(2));
        imm12  = 12'(randBits(12));
        a      = regs[rs1];
        b      = regs[rs2];
        nextPc = modelPc + 32'd4;
        value  = '0;
        writes = 1'b0;
        jumps  = 1'b0;
        clearExpect();
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
                alt    = alt && (f3 == 3'b000 || f3 == 3'b101);
                word   = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
                writes = 1'b1;
                value  = aluModel(f3, alt, a, b);
            end
            4'd5, 4'd6, 4'd7, 4'd8: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    alt   = alt && f3 == 3'b101;
                    imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
                end else begin
                    alt = 1'b0;
                end
                word   = {imm12, rs1, f3, rd, 7'b0010011};
                writes = 1'b1;
                value  = aluModel(f3, alt, a, sext12(imm12));
            end
            4'd9: begin
                immU   = 20'(randBits(20));
                word   = {immU, rd, 7'b0110111};
                writes = 1'b1;
                value  = {immU, 12'b0};
            end
            4'd10, 4'd11: begin
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;
                end
                immB  = {imm12, 1'b0};
                word  = {immB[12], immB[10:5], rs2, rs1, f3, immB[4:1], immB[11], 7'b1100011};
                jumps = branchTaken(f3, a, b);
                if (jumps) begin
                    nextPc = modelPc + {{19{immB[12]}}, immB};
                end
            end
            4'd12: begin
                immJ   = {20'(randBits(20)), 1'b0};
                word   = {immJ[20], immJ[10:1], immJ[11], immJ[19:12], rd, 7'b1101111};
                writes = 1'b1;
                jumps  = 1'b1;
                value  = modelPc + 32'd4;
                nextPc = modelPc + {{11{immJ[20]}}, immJ};
            end
            4'd13: begin
                word   = {imm12, rs1, 3'b000, rd, 7'b1100111};
                writes = 1'b1;
                jumps  = 1'b1;
                value  = modelPc + 32'd4;
                nextPc = (a + sext12(imm12)) & ~32'd1;
            end
            default: begin
                // load opcode, or a branch with a reserved funct3.
                if (alt) begin
                    word = {imm12, rs1, f3, rd, 7'b0000011};
                end else begin
                    word = {7'b0, rs2, rs1, 2'b01, f3[0], 5'b0, 7'b1100011};
                end
            end
        endcase
        if (writes && rd != '0) begin
            regs[rd]  = value;
            exWbValid = 1'b1;
            exWbRd    = rd;
            exWbData  = value;
        end
        exRedirect   = jumps;
        exRedirectPc = jumps ? nextPc : '0;
        instrValid   = 1'b1;
        instr        = word;
        pc           = modelPc;
        modelPc      = nextPc;
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > MAX_CYCLES) begin
                stopRun($sformatf("timeout: test did not finish within %0d cycles",
                                  MAX_CYCLES));
            end
        end
    end

    initial begin
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        lfsr       = 32'h4ff0ac8a;
        modelPc    = 32'h0000_1000;
        wbExpValid = 1'b0;
        wbExpRd    = '0;
        wbExpData  = '0;
        for (int i = 0; i < `RV_NREGS; i++) begin
            regs[i] = '0;
        end
        clearExpect();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int n = 0; n < NUM_INSTR; n++) begin
            if (randBits(3) == 32'd0) begin
                advance();
                presentFiller(1'b0, modelPc);
            end
            advance();
            presentInstr();
            // the slot after a redirect carries a wrong-path word.
            if (exRedirect) begin
                advance();
                presentFiller(1'b1, pc + 32'd4);
            end
        end
        repeat (3) begin
            advance();
            presentFiller(1'b0, modelPc);
        end
        if (u_rvCoreSlice.u_sva.failCount == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stopRun($sformatf("%0d pipeline assertion failures were reported",
                              u_rvCoreSlice.u_sva.failCount));
        end
    end

endmodule

//--- rvCoreSlice_sva.sv
module rvCoreSlice_sva (
    input logic            clk,
    input logic            rst,
    input logic            flush,
    input rvPkg::ctrl_t    exCtrl,
    input logic            wbValid,
    input rvPkg::regAddr_t wbRd,
    input logic            redirect
);

    int failCount = 0;

    // the slot captured under a flush holds no control.
    flushBubble: assert property (@(posedge clk) disable iff (rst) flush |=> exCtrl == '0)
        else begin
            failCount = failCount + 1;
            $error("flush was not followed by a bubble in execute");
        end

    wbNotZero: assert property (@(posedge clk) disable iff (rst) wbValid |-> wbRd != '0)
        else begin
            failCount = failCount + 1;
            $error("writeback valid with destination x0");
        end

    bubbleQuiet: assert property (@(posedge clk) disable iff (rst) exCtrl == '0 |-> !redirect)
        else begin
            failCount = failCount + 1;
            $error("redirect raised while execute holds a bubble");
        end

endmodule

//--- rvCoreSlice.sv
module rvCoreSlice (
    input  logic            clk,
    input  logic            rst,
    input  logic            instrValid,
    input  rvPkg::instr_u   instr,
    input  rvPkg::word_t    pc,
    output logic            wbValid,
    output rvPkg::regAddr_t wbRd,
    output rvPkg::word_t    wbData,
    output logic            redirect,
    output rvPkg::word_t    redirectPc
);

    rvPkg::regAddr_t rs1;
    rvPkg::regAddr_t rs2;
    logic            flush;

    // payload ahead of and behind the pipeline register.
    idExIf idIf ();
    idExIf exIf ();

    instrDecoder u_decoder (
        .valid (instrValid),
        .instr (instr),
        .pc    (pc),
        .rs1   (rs1),
        .rs2   (rs2),
        .dec   (idIf.dec)
    );

    regFile u_regFile (
        .clk (clk),
        .rst (rst),
        .rs1 (rs1),
        .rs2 (rs2),
        .rd1 (idIf.rd1),
        .rd2 (idIf.rd2),
        .we  (wbValid),
        .wa  (wbRd),
        .wd  (wbData)
    );

    // a redirect squashes the wrong-path instruction being captured.
    decodeExecuteReg u_idExReg (
        .clk (clk),
        .clr (rst | flush),
        .d   (idIf.dec),
        .e   (exIf)
    );

    executeStage u_execute (
        .clk        (clk),
        .rst        (rst),
        .e          (exIf.exe),
        .flush      (flush),
        .wbValid    (wbValid),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

endmodule

//--- executeStage.sv
module executeStage (
    input  logic            clk,
    input  logic            rst,
    idExIf.exe              e,
    output logic            flush,
    output logic            wbValid,
    output rvPkg::regAddr_t wbRd,
    output rvPkg::word_t    wbData,
    output logic            redirect,
    output rvPkg::word_t    redirectPc
);

    rvPkg::word_t srcA;
    rvPkg::word_t rs2Val;
    rvPkg::word_t srcB;
    rvPkg::word_t aluResult;
    rvPkg::word_t result;
    logic         cmp;
    logic         taken;
    logic         wbEn;

    // wbValid already implies a nonzero rd.
    assign srcA   = (wbValid && wbRd == e.rs1) ? wbData : e.rd1;
    assign rs2Val = (wbValid && wbRd == e.rs2) ? wbData : e.rd2;
    assign srcB   = e.ctrl.aluSrc ? e.immExt : rs2Val;

    always_comb begin
        case (e.ctrl.aluControl)
            rvPkg::ALU_ADD:  aluResult = srcA + srcB;
            rvPkg::ALU_SUB:  aluResult = srcA - srcB;
            rvPkg::ALU_SLL:  aluResult = srcA << srcB[4:0];
            rvPkg::ALU_SLT:  aluResult = rvPkg::word_t'($signed(srcA) < $signed(srcB));
            rvPkg::ALU_SLTU: aluResult = rvPkg::word_t'(srcA < srcB);
            rvPkg::ALU_XOR:  aluResult = srcA ^ srcB;
            rvPkg::ALU_SRL:  aluResult = srcA >> srcB[4:0];
            rvPkg::ALU_SRA:  aluResult = rvPkg::word_t'($signed(srcA) >>> srcB[4:0]);
            rvPkg::ALU_OR:   aluResult = srcA | srcB;
            rvPkg::ALU_AND:  aluResult = srcA & srcB;
            default:         aluResult = srcA + srcB;
        endcase
    end

    // branches compare the two register operands, never the immediate.
    always_comb begin
        case (e.ctrl.branch[2:1])
            2'b01:   cmp = srcA == rs2Val;
            2'b10:   cmp = $signed(srcA) < $signed(rs2Val);
            2'b11:   cmp = srcA < rs2Val;
            default: cmp = 1'b0;
        endcase
    end

    assign taken = e.ctrl.branch[2:1] != 2'b00 && (cmp ^ e.ctrl.branch[0]);

    assign redirect = taken || e.ctrl.jump != rvPkg::JUMP_NONE;
    // jalr target is rs1 + imm from the adder, low bit dropped.
    assign redirectPc = (e.ctrl.jump == rvPkg::JUMP_JALR) ? {aluResult[31:1], 1'b0}
                                                          : e.pc + e.immExt;
    assign flush = redirect;

    assign result = e.ctrl.resultSrc ? e.pcPlus4 : aluResult;
    assign wbEn   = e.ctrl.regWrite && e.rd != '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= wbEn;
        end
    end

    always_ff @(posedge clk) begin
        if (wbEn) begin
            wbRd   <= e.rd;
            wbData <= result;
        end
    end

endmodule

//--- decodeExecuteReg.sv
module decodeExecuteReg (
    input  logic clk,
    input  logic clr,
    idExIf.dec   d,
    idExIf       e
);

    // a clear turns the slot into a bubble with all control low.
    always_ff @(posedge clk) begin
        if (clr) begin
            e.ctrl    <= '0;
            e.rd1     <= '0;
            e.rd2     <= '0;
            e.pc      <= '0;
            e.pcPlus4 <= '0;
            e.rs1     <= '0;
            e.rs2     <= '0;
            e.rd      <= '0;
            e.immExt  <= '0;
        end else begin
            e.ctrl    <= d.ctrl;
            e.rd1     <= d.rd1;
            e.rd2     <= d.rd2;
            e.pc      <= d.pc;
            e.pcPlus4 <= d.pcPlus4;
            e.rs1     <= d.rs1;
            e.rs2     <= d.rs2;
            e.rd      <= d.rd;
            e.immExt  <= d.immExt;
        end
    end

endmodule

//--- regFile.sv
`include "rvCore_cfg.svh"

module regFile (
    input  logic            clk,
    input  logic            rst,
    input  rvPkg::regAddr_t rs1,
    input  rvPkg::regAddr_t rs2,
    output rvPkg::word_t    rd1,
    output rvPkg::word_t    rd2,
    input  logic            we,
    input  rvPkg::regAddr_t wa,
    input  rvPkg::word_t    wd
);

    rvPkg::word_t regs [`RV_NREGS];
    logic         wrLive;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    assign wrLive = we && wa != '0;

    // the writeback register commits one cycle after execute, so a read of
    // the register being committed returns the committing data.
    always_comb begin
        rd1 = regs[rs1];
        rd2 = regs[rs2];
        if (wrLive && wa == rs1) begin
            rd1 = wd;
        end
        if (wrLive && wa == rs2) begin
            rd2 = wd;
        end
    end

endmodule

//--- instrDecoder.sv
module instrDecoder (
    input  logic            valid,
    input  rvPkg::instr_u   instr,
    input  rvPkg::word_t    pc,
    output rvPkg::regAddr_t rs1,
    output rvPkg::regAddr_t rs2,
    idExIf.dec              dec
);

    rvPkg::ctrl_t ctrl;
    rvPkg::word_t immExt;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    logic         shiftOp;
    logic         legalR;
    logic         legalI;
    logic         legal;

    function automatic rvPkg::aluOp_e aluOp(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  aluOp = alt ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
            3'b001:  aluOp = rvPkg::ALU_SLL;
            3'b010:  aluOp = rvPkg::ALU_SLT;
            3'b011:  aluOp = rvPkg::ALU_SLTU;
            3'b100:  aluOp = rvPkg::ALU_XOR;
            3'b101:  aluOp = alt ? rvPkg::ALU_SRA : rvPkg::ALU_SRL;
            3'b110:  aluOp = rvPkg::ALU_OR;
            default: aluOp = rvPkg::ALU_AND;
        endcase
    endfunction

    assign funct3  = instr.rType.funct3;
    assign funct7  = instr.rType.funct7;
    assign shiftOp = funct3 == 3'b001 || funct3 == 3'b101;

    // bit 30 is only legal on sub and sra in register form.
    assign legalR = funct7 == 7'b0000000
                 || (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    // the immediate form checks funct7 only on shifts.
    assign legalI = !shiftOp || funct7 == 7'b0000000
                 || (funct7 == 7'b0100000 && funct3 == 3'b101);

    always_comb begin
        ctrl   = '0;
        immExt = '0;
        legal  = 1'b1;
        rs1    = instr.rType.rs1;
        case (instr.rType.opcode)
            rvPkg::OPC_OP: begin
                legal           = legalR;
                ctrl.regWrite   = 1'b1;
                ctrl.aluControl = aluOp(funct3, funct7[5]);
            end
            rvPkg::OPC_OP_IMM: begin
                legal           = legalI;
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrc     = 1'b1;
                ctrl.aluControl = aluOp(funct3, funct7[5] && funct3 == 3'b101);
                immExt          = {{20{instr.iType.imm[11]}}, instr.iType.imm};
            end
            rvPkg::OPC_LUI: begin
                // lui adds its immediate to x0.
                rs1             = '0;
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrc     = 1'b1;
                ctrl.aluControl = rvPkg::ALU_ADD;
                immExt          = {instr.uType.imm31_12, 12'b0};
            end
            rvPkg::OPC_BRANCH: begin
                legal       = funct3[2:1] != 2'b01;
                ctrl.branch = {funct3[2] ? {1'b1, funct3[1]} : 2'b01, funct3[0]};
                immExt      = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
                               instr.bType.imm10_5, instr.bType.imm4_1, 1'b0};
            end
            rvPkg::OPC_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = 1'b1;
                ctrl.jump      = rvPkg::JUMP_JAL;
                immExt         = {{11{instr.jType.imm20}}, instr.jType.imm20,
                                  instr.jType.imm19_12, instr.jType.imm11,
                                  instr.jType.imm10_1, 1'b0};
            end
            rvPkg::OPC_JALR: begin
                legal           = funct3 == 3'b000;
                ctrl.regWrite   = 1'b1;
                ctrl.resultSrc  = 1'b1;
                ctrl.jump       = rvPkg::JUMP_JALR;
                ctrl.aluSrc     = 1'b1;
                ctrl.aluControl = rvPkg::ALU_ADD;
                immExt          = {{20{instr.iType.imm[11]}}, instr.iType.imm};
            end
            default: legal = 1'b0;
        endcase
        // anything unsupported, or no instruction at all, becomes a bubble.
        if (!valid || !legal) begin
            ctrl = '0;
        end
    end

    assign rs2 = instr.rType.rs2;

    assign dec.ctrl    = ctrl;
    assign dec.pc      = pc;
    assign dec.pcPlus4 = pc + 4;
    assign dec.rs1     = rs1;
    assign dec.rs2     = rs2;
    assign dec.rd      = instr.rType.rd;
    assign dec.immExt  = immExt;

endmodule

//--- idExIf.sv
interface idExIf;

    rvPkg::ctrl_t    ctrl;
    rvPkg::word_t    rd1;
    rvPkg::word_t    rd2;
    rvPkg::word_t    pc;
    rvPkg::word_t    pcPlus4;
    rvPkg::regAddr_t rs1;
    rvPkg::regAddr_t rs2;
    rvPkg::regAddr_t rd;
    rvPkg::word_t    immExt;

    // producer side, filled in during decode.
    modport dec (
        output ctrl,
        output rd1,
        output rd2,
        output pc,
        output pcPlus4,
        output rs1,
        output rs2,
        output rd,
        output immExt
    );

    // consumer side, read by execute.
    modport exe (
        input ctrl,
        input rd1,
        input rd2,
        input pc,
        input pcPlus4,
        input rs1,
        input rs2,
        input rd,
        input immExt
    );

endinterface

//--- rvPkg.sv
`include "rvCore_cfg.svh"

package rvPkg;

    typedef logic [`RV_REG_AW-1:0] regAddr_t;
    typedef logic [`RV_XLEN-1:0]   word_t;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } aluOp_e;

    typedef enum logic [1:0] {
        JUMP_NONE,
        JUMP_JAL,
        JUMP_JALR
    } jump_e;

    // one instruction word seen through each base format.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            regAddr_t   rs2;
            regAddr_t   rs1;
            logic [2:0] funct3;
            regAddr_t   rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            regAddr_t    rs1;
            logic [2:0]  funct3;
            regAddr_t    rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            regAddr_t   rs2;
            regAddr_t   rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } bType;
        struct packed {
            logic [19:0] imm31_12;
            regAddr_t    rd;
            logic [6:0]  opcode;
        } uType;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            regAddr_t   rd;
            logic [6:0] opcode;
        } jType;
    } instr_u;

    // branch[2:1] is the compare kind (00 none, 01 eq, 10 lt, 11 ltu).
    // branch[0] inverts the compare for bne, bge and bgeu.
    typedef struct packed {
        logic       regWrite;
        logic       resultSrc;
        jump_e      jump;
        logic [2:0] branch;
        aluOp_e     aluControl;
        logic       aluSrc;
    } ctrl_t;

endpackage

//--- rvCore_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// data word width.
`define RV_XLEN 32
// register address width.
`define RV_REG_AW 5
// architectural register count.
`define RV_NREGS 32

`endif
